//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'test passed' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_apb_regs.sv
hdl/uart_top.sv
tb/uart_tb.sv

//--- hdl/uart_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_apb_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  uart_pkg::apb_req_t      apb_req,
    output uart_pkg::apb_rsp_t      apb_rsp,
    output logic                    tx_push,
    output logic [7:0]              tx_wdata,
    input  logic                    tx_full,
    input  logic                    tx_empty,
    input  logic                    rx_push,
    input  uart_pkg::uart_rx_word_t rx_word,
    output logic                    rx_fifo_push,
    output logic                    rx_pop,
    input  uart_pkg::uart_rx_word_t rx_rdata,
    input  logic                    rx_full,
    input  logic                    rx_empty
);

    logic                   access;
    logic                   sel_data;
    logic                   sel_status;
    logic                   sel_clear;
    logic                   data_wr;
    logic                   data_rd;
    logic                   status_rd;
    logic                   clear_wr;
    logic                   overrun_q;
    logic                   frame_err_q;
    uart_pkg::uart_status_t status;
    uart_pkg::uart_status_t clr_mask;

    assign access     = apb_req.psel && apb_req.penable; // Access phase.
    assign sel_data   = (apb_req.paddr == `UART_ADDR_DATA);
    assign sel_status = (apb_req.paddr == `UART_ADDR_STATUS);
    assign sel_clear  = (apb_req.paddr == `UART_ADDR_CLEAR);

    assign data_wr   = access && apb_req.pwrite && sel_data;
    assign data_rd   = access && !apb_req.pwrite && sel_data;
    assign status_rd = access && !apb_req.pwrite && sel_status;
    assign clear_wr  = access && apb_req.pwrite && sel_clear;

    assign tx_push  = data_wr && !tx_full;
    assign tx_wdata = apb_req.pwdata[7:0];
    assign rx_pop   = data_rd && !rx_empty;

    // Byte is dropped when the receive FIFO is full.
    assign rx_fifo_push = rx_push && !rx_full;

    assign clr_mask = uart_pkg::uart_status_t'(apb_req.pwdata[4:0]);

    // A new event wins over a clear in the same cycle.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (rx_push && rx_full) begin
                overrun_q <= 1'b1;
            end else if (clear_wr && clr_mask.overrun) begin
                overrun_q <= 1'b0;
            end
            if (rx_fifo_push && rx_word.frame_err) begin
                frame_err_q <= 1'b1;
            end else if (clear_wr && clr_mask.frame_err) begin
                frame_err_q <= 1'b0;
            end
        end
    end

    always_comb begin
        status.rx_valid  = !rx_empty;
        status.tx_full   = tx_full;
        status.tx_empty  = tx_empty;
        status.overrun   = overrun_q;
        status.frame_err = frame_err_q;
    end

    always_comb begin
        apb_rsp.prdata = 32'h0;
        if (data_rd && !rx_empty) begin
            apb_rsp.prdata = {23'h0, rx_rdata};
        end else if (status_rd) begin
            apb_rsp.prdata = {27'h0, status};
        end
        apb_rsp.pslverr = access && (!(sel_data || sel_status || sel_clear)
                                     || (data_wr && tx_full)
                                     || (data_rd && rx_empty));
    end

endmodule

`default_nettype wire

//--- hdl/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Clocks per bit period. Keep it even.
`define UART_CLK_PER_BIT 16

// Entries per FIFO, power of two.
`define UART_FIFO_DEPTH 8

// Register offsets on the APB bus.
`define UART_ADDR_DATA   4'h0
`define UART_ADDR_STATUS 4'h4
`define UART_ADDR_CLEAR  4'h8

`endif

//--- hdl/uart_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr; // Extra bit tells a wrap.
    logic [AW:0]      rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign rdata = mem[rd_ptr[AW-1:0]]; // Head entry.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Master to UART.
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // UART to master.
    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // Received frame, frame_err lands in bit 8 of DATA.
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } uart_rx_word_t;

    // STATUS image, rx_valid in bit 0.
    typedef struct packed {
        logic frame_err;
        logic overrun;
        logic tx_empty;
        logic tx_full;
        logic rx_valid;
    } uart_status_t;

endpackage

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_rx (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    rxd,
    output logic                    rx_push,
    output uart_pkg::uart_rx_word_t rx_word
);

    localparam int CPB   = `UART_CLK_PER_BIT;
    localparam int HALF  = CPB / 2;
    localparam int CNT_W = $clog2(CPB);

    localparam logic [2:0] S_HOLD  = 3'd0; // Waits for a high line.
    localparam logic [2:0] S_IDLE  = 3'd1;
    localparam logic [2:0] S_START = 3'd2;
    localparam logic [2:0] S_DATA  = 3'd3;
    localparam logic [2:0] S_STOP  = 3'd4;

    logic [4:0]       sync_q;
    logic             agree;
    logic             line;
    logic [2:0]       state;
    logic [2:0]       bit_idx;
    logic [CNT_W-1:0] bit_cnt;
    logic             half_evt;
    logic             full_evt;
    logic             cnt_clr;
    logic [7:0]       shift_q;

    // Synchroniser and deglitch chain.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sync_q <= 5'h1f;
        end else begin
            sync_q <= {sync_q[3:0], rxd};
        end
    end

    assign agree = (sync_q == 5'h1f) || (sync_q == 5'h00);
    assign line  = sync_q[4];

    assign half_evt = (bit_cnt == CNT_W'(HALF - 1));
    assign full_evt = (bit_cnt == CNT_W'(CPB - 1));

    always_comb begin
        case (state)
            S_HOLD, S_IDLE: cnt_clr = 1'b1;
            S_START:        cnt_clr = half_evt;
            default:        cnt_clr = full_evt && agree;
        endcase
    end

    // Holds at the full-bit count until the stages agree.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bit_cnt <= '0;
        end else if (cnt_clr) begin
            bit_cnt <= '0;
        end else if (!full_evt) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= S_HOLD;
            bit_idx <= 3'd0;
            rx_push <= 1'b0;
        end else begin
            rx_push <= 1'b0;
            case (state)
                S_HOLD: begin
                    if (agree && line) begin
                        state <= S_IDLE;
                    end
                end
                S_IDLE: begin
                    if (agree && !line) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (half_evt) begin // Middle of the start bit.
                        state   <= S_DATA;
                        bit_idx <= 3'd0;
                    end
                end
                S_DATA: begin
                    if (full_evt && agree) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                S_STOP: begin
                    if (full_evt && agree) begin
                        rx_push <= 1'b1;
                        state   <= line ? S_IDLE : S_HOLD;
                    end
                end
                default: state <= S_HOLD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DATA && full_evt && agree) begin
            shift_q <= {line, shift_q[7:1]}; // LSB first.
        end
        if (state == S_STOP && full_evt && agree) begin
            rx_word.data      <= shift_q;
            rx_word.frame_err <= !line;
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_top (
    input  logic               clk,
    input  logic               rstn,
    input  uart_pkg::apb_req_t apb_req,
    output uart_pkg::apb_rsp_t apb_rsp,
    input  logic               rxd,
    output logic               txd
);

    logic                    tx_push;
    logic [7:0]              tx_wdata;
    logic                    tx_pop;
    logic [7:0]              tx_rdata;
    logic                    tx_full;
    logic                    tx_empty;
    logic                    rx_push;
    logic                    rx_fifo_push;
    logic                    rx_pop;
    logic                    rx_full;
    logic                    rx_empty;
    uart_pkg::uart_rx_word_t rx_word;
    uart_pkg::uart_rx_word_t rx_rdata;

    uart_apb_regs i_uart_apb_regs (
        .clk          (clk),
        .rstn         (rstn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .tx_push      (tx_push),
        .tx_wdata     (tx_wdata),
        .tx_full      (tx_full),
        .tx_empty     (tx_empty),
        .rx_push      (rx_push),
        .rx_word      (rx_word),
        .rx_fifo_push (rx_fifo_push),
        .rx_pop       (rx_pop),
        .rx_rdata     (rx_rdata),
        .rx_full      (rx_full),
        .rx_empty     (rx_empty)
    );

    uart_fifo #(
        .WIDTH (8),
        .DEPTH (`UART_FIFO_DEPTH)
    ) i_tx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (tx_push),
        .wdata (tx_wdata),
        .pop   (tx_pop),
        .rdata (tx_rdata),
        .full  (tx_full),
        .empty (tx_empty)
    );

    // Holds frame_err alongside each byte.
    uart_fifo #(
        .WIDTH ($bits(uart_pkg::uart_rx_word_t)),
        .DEPTH (`UART_FIFO_DEPTH)
    ) i_rx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (rx_fifo_push),
        .wdata (rx_word),
        .pop   (rx_pop),
        .rdata (rx_rdata),
        .full  (rx_full),
        .empty (rx_empty)
    );

    uart_rx i_uart_rx (
        .clk     (clk),
        .rstn    (rstn),
        .rxd     (rxd),
        .rx_push (rx_push),
        .rx_word (rx_word)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rstn     (rstn),
        .tx_empty (tx_empty),
        .tx_pop   (tx_pop),
        .tx_data  (tx_rdata),
        .txd      (txd)
    );

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rstn,
    input  logic       tx_empty,
    output logic       tx_pop,
    input  logic [7:0] tx_data,
    output logic       txd
);

    localparam int CPB   = `UART_CLK_PER_BIT;
    localparam int CNT_W = $clog2(CPB);

    logic             busy;
    logic [9:0]       frame_q;
    logic [9:0]       frame_next;
    logic [CNT_W-1:0] bit_cnt;
    logic [3:0]       bit_idx;
    logic             bit_end;
    logic             frame_end;

    assign bit_end   = busy && (bit_cnt == CNT_W'(CPB - 1));
    assign frame_end = bit_end && (bit_idx == 4'd9);

    // Next byte is taken as the stop bit ends, so frames run back to back.
    assign tx_pop = (!busy || frame_end) && !tx_empty;

    always_comb begin
        frame_next = frame_q;
        if (tx_pop) begin
            frame_next = {1'b1, tx_data, 1'b0}; // Stop, data, start.
        end else if (bit_end) begin
            frame_next = {1'b1, frame_q[9:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            frame_q <= '1;
            txd     <= 1'b1;
        end else begin
            frame_q <= frame_next;
            txd     <= frame_next[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= 4'd0;
        end else if (tx_pop) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            bit_idx <= 4'd0;
        end else if (frame_end) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_config.svh"

module uart_tb;

    localparam int CPB   = `UART_CLK_PER_BIT;
    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int LIMIT = 200 * 10 * CPB + 2000; // Cycles before the run is abandoned.

    logic                    clk = 1'b0;
    logic                    rstn;
    uart_pkg::apb_req_t      apb_req;
    uart_pkg::apb_rsp_t      apb_rsp;
    logic                    rxd;
    logic                    txd;
    logic                    ser_rxd;
    logic                    loopback; // Selects txd as the source of rxd.
    logic [31:0]             lcg_state;
    uart_pkg::uart_rx_word_t exp_q[$];
    logic                    model_overrun;
    logic                    model_frame_err;
    int                      errors = 0;
    int                      checks = 0;
    int                      cycles = 0;

    uart_top i_uart_top (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .rxd     (rxd),
        .txd     (txd)
    );

    assign rxd = loopback ? txd : ser_rxd;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding.", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic int unsigned lcg(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 8) % n; // Upper bits are the better ones.
    endfunction

    task check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // Setup phase, then access phase sampled at the falling edge.
    task apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                    output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task apb_write(input logic [3:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] ignored;
        apb_access(1'b1, addr, wdata, ignored, err);
    endtask

    task apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    // One frame, start bit first, every bit CPB clocks.
    task serial_send(input logic [7:0] data, input logic stop);
        logic [9:0] frame;
        int         i;
        frame = {stop, data, 1'b0};
        @(posedge clk);
        #1;
        for (i = 0; i < 10; i++) begin
            ser_rxd = frame[i];
            repeat (CPB) @(posedge clk);
            #1;
        end
        ser_rxd = 1'b1;
        if (!stop) begin
            repeat (CPB) @(posedge clk); // Line must go high before the next start.
        end
    endtask

    task receive_expected();
        logic [31:0]             rd;
        logic                    err;
        uart_pkg::uart_rx_word_t exp;
        do begin
            apb_read(`UART_ADDR_STATUS, rd, err);
        end while (!rd[0]);
        apb_read(`UART_ADDR_DATA, rd, err);
        exp = exp_q.pop_front();
        check("pslverr", 32'(err), 32'd0);
        check("rx_word", rd, 32'(exp));
    endtask

    task check_flags();
        logic [31:0] rd;
        logic        err;
        apb_read(`UART_ADDR_STATUS, rd, err);
        check("status.rx_valid", 32'(rd[0]), 32'(exp_q.size() != 0));
        check("status.overrun", 32'(rd[3]), 32'(model_overrun));
        check("status.frame_err", 32'(rd[4]), 32'(model_frame_err));
    endtask

    // Bursts within the FIFO depth, each read back before the next.
    task send_bursts(input int total);
        int                      left;
        int                      n;
        logic [7:0]              b;
        logic                    err;
        uart_pkg::uart_rx_word_t w;
        left = total;
        while (left > 0) begin
            n = int'(lcg(DEPTH)) + 1;
            if (n > left) begin
                n = left;
            end
            repeat (n) begin
                b = 8'(lcg(256));
                if (loopback) begin
                    apb_write(`UART_ADDR_DATA, {24'h0, b}, err);
                    check("pslverr", 32'(err), 32'd0);
                end else begin
                    serial_send(b, 1'b1);
                    repeat (lcg(32)) @(posedge clk);
                end
                w.data      = b;
                w.frame_err = 1'b0;
                exp_q.push_back(w);
            end
            repeat (n) receive_expected();
            left = left - n;
        end
    endtask

    initial begin
        logic [31:0]             rd;
        logic                    err;
        logic [7:0]              b;
        uart_pkg::uart_rx_word_t w;
        int                      i;
        int                      cnt;
        apb_req         = '0;
        ser_rxd         = 1'b1;
        loopback        = 1'b1;
        rstn            = 1'b0;
        lcg_state       = 32'hab8d;
        model_overrun   = 1'b0;
        model_frame_err = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        check("txd", 32'(txd), 32'd1);
        check_flags();

        send_bursts(40); // Loopback.
        loopback = 1'b0;
        send_bursts(40);

        repeat (3) begin // Stop bit read as 0.
            b = 8'(lcg(256));
            serial_send(b, 1'b0);
            w.data      = b;
            w.frame_err = 1'b1;
            exp_q.push_back(w);
            model_frame_err = 1'b1;
        end
        check_flags();
        repeat (3) receive_expected();
        check_flags();
        apb_write(`UART_ADDR_CLEAR, 32'h10, err);
        model_frame_err = 1'b0;
        check_flags();

        repeat (DEPTH + 3) begin
            b = 8'(lcg(256));
            serial_send(b, 1'b1);
            if (exp_q.size() < DEPTH) begin
                w.data      = b;
                w.frame_err = 1'b0;
                exp_q.push_back(w);
            end
        end
        model_overrun = 1'b1;
        check_flags();
        repeat (DEPTH) receive_expected();
        check_flags();
        apb_read(`UART_ADDR_DATA, rd, err);
        check("pslverr", 32'(err), 32'd1);
        check("prdata", rd, 32'h0);
        apb_write(`UART_ADDR_CLEAR, 32'h08, err);
        model_overrun = 1'b0;
        check_flags();

        repeat (6) begin // Low pulses shorter than the deglitch chain.
            @(posedge clk);
            #1;
            ser_rxd = 1'b0;
            repeat (lcg(4) + 1) @(posedge clk);
            #1;
            ser_rxd = 1'b1;
            repeat (10) @(posedge clk);
        end
        repeat (11 * CPB) @(posedge clk); // Long enough for a false frame to land.
        check_flags();
        send_bursts(1);

        apb_read(4'hc, rd, err);
        check("pslverr", 32'(err), 32'd1);
        cnt = 0;
        for (i = 0; i < DEPTH + 2; i++) begin
            b = 8'(lcg(256));
            apb_write(`UART_ADDR_DATA, {24'h0, b}, err);
            check("pslverr", 32'(err), 32'(cnt == DEPTH));
            if (cnt < DEPTH) begin
                cnt = cnt + 1;
            end
            if (i == 0) begin
                cnt = cnt - 1; // Taken by the idle transmitter.
            end
            apb_read(`UART_ADDR_STATUS, rd, err);
            check("status.tx_full", 32'(rd[1]), 32'(cnt == DEPTH));
            check("status.tx_empty", 32'(rd[2]), 32'(cnt == 0));
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
